// ==== common/control_pkg.sv ====
`default_nettype none

package controlPkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Sequencer phases
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        Fetch,
        Add,
        Sub,
        And,
        Slt,
        Sll,
        Sra,
        Srl,
        Addi,
        Halt
    } state_t;

    typedef logic [2:0] step_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Instruction fields
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [5:0] {
        RType  = 6'b000000,
        AddiOp = 6'b001000,
        HaltOp = 6'b111111
    } opcode_t;

    // Low six bits of the offset field
    typedef enum logic [5:0] {
        AddFn = 6'b100000,
        SubFn = 6'b100010,
        AndFn = 6'b100100,
        SllFn = 6'b000000,
        SltFn = 6'b101010,
        SraFn = 6'b000011,
        SrlFn = 6'b000010
    } funct_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Datapath selects
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        AluNone = 3'b000,
        AluAdd  = 3'b001,
        AluSub  = 3'b010,
        AluAnd  = 3'b011,
        AluSlt  = 3'b111
    } aluOp_t;

    typedef enum logic [2:0] {
        ShNone       = 3'b000,
        ShLoad       = 3'b001,
        ShLeft       = 3'b010, // Also the write-back cycle
        ShRightLogic = 3'b011,
        ShRightArith = 3'b100
    } shiftOp_t;

    typedef enum logic [1:0] {
        SrcBReg  = 2'b00,
        SrcBFour = 2'b01,
        SrcBImm  = 2'b10
    } srcB_t;

    typedef enum logic [1:0] {
        DestRt = 2'b00,
        DestRd = 2'b01
    } regDest_t;

    typedef enum logic [3:0] {
        WbAlu      = 4'b0000,
        WbLessThan = 4'b0100,
        WbShifter  = 4'b1000
    } memToReg_t;

    // Last step of each phase
    localparam step_t FetchLast     = 3'd5; // Decode step
    localparam step_t AluExecLast   = 3'd1;
    localparam step_t ShiftExecLast = 3'd2;
    localparam step_t SltExecLast   = 3'd0;

endpackage

`default_nettype wire

// ==== hw/sequencer/stepCounter.sv ====
`default_nettype none

module stepCounter (
    input  wire logic               clock,
    input  wire logic               reset,
    input  var  controlPkg::step_t  lastStep,
    input  wire logic               stepClear,
    output controlPkg::step_t       step,
    output logic                    stepDone
);
    import controlPkg::*;

    assign stepDone = (step == lastStep);

    always_ff @(posedge clock) begin
        if (reset) begin
            step <= '0;
        end else if (stepClear) begin
            step <= '0;
        end else begin
            step <= step + 3'd1;
        end
    end

    // Sequencer must wrap before the counter passes decode
    stepInRange: assert property (@(posedge clock) disable iff (reset)
        step <= FetchLast);

endmodule

`default_nettype wire

// ==== hw/sequencer/phaseSequencer.sv ====
`default_nettype none

module phaseSequencer (
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                stepDone,
    input  var  controlPkg::state_t  execState,
    input  wire logic                execValid,
    output controlPkg::state_t       state,
    output controlPkg::step_t        lastStep,
    output logic                     stepClear
);
    import controlPkg::*;

    state_t nextState;

    // ~~~~~~~~~~~~~~~~~~~~
    // Next state
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        nextState = state;
        case (state)
            Fetch: begin
                if (stepDone && execValid) begin
                    nextState = execState; // Leave after decode
                end
            end
            Halt: begin
                nextState = Halt;
            end
            default: begin
                if (stepDone) begin
                    nextState = Fetch;
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= Fetch;
        end else begin
            state <= nextState;
        end
    end

    // Phase length
    always_comb begin
        case (state)
            Fetch:               lastStep = FetchLast;
            Add, Sub, And, Addi: lastStep = AluExecLast;
            Sll, Sra, Srl:       lastStep = ShiftExecLast;
            Slt:                 lastStep = SltExecLast;
            default:             lastStep = '0; // Halt parks on step 0
        endcase
    end

    // Counter restarts at each phase boundary
    assign stepClear = stepDone;

    haltAbsorbing: assert property (@(posedge clock) disable iff (reset)
        state == Halt |=> state == Halt);

endmodule

`default_nettype wire

// ==== hw/instructionDecoder.sv ====
`default_nettype none

module instructionDecoder (
    input  var controlPkg::opcode_t opcode,
    input  var controlPkg::funct_t  funct,
    output controlPkg::state_t      execState,
    output logic                    execValid
);
    import controlPkg::*;

    always_comb begin
        execState = Fetch;
        execValid = 1'b1;

        case (opcode)
            RType: begin
                // Function field picks the operation
                case (funct)
                    AddFn: execState = Add;
                    SubFn: execState = Sub;
                    AndFn: execState = And;
                    SltFn: execState = Slt;
                    SllFn: execState = Sll;
                    SraFn: execState = Sra;
                    SrlFn: execState = Srl;
                    default: begin
                        execValid = 1'b0; // Replay fetch, no write
                    end
                endcase
            end
            AddiOp: begin
                execState = Addi;
            end
            HaltOp: begin
                execState = Halt;
            end
            default: begin
                execValid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/controlWordEncoder.sv ====
`default_nettype none

module controlWordEncoder (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  var  controlPkg::state_t   state,
    input  var  controlPkg::step_t    step,
    output logic                      pcWrite,
    output logic                      irWrite,
    output logic                      regWrite,
    output logic                      aWrite,
    output logic                      bWrite,
    output logic                      aluOutWrite,
    output controlPkg::aluOp_t        aluOp,
    output logic                      srcASel,
    output controlPkg::srcB_t         srcBSel,
    output controlPkg::regDest_t      regDestSel,
    output controlPkg::memToReg_t     memToRegSel,
    output logic                      shiftAmtSel,
    output logic                      shiftSrcSel,
    output controlPkg::shiftOp_t      shiftOp,
    output logic                      resetOut
);
    import controlPkg::*;

    aluOp_t   execAluOp;
    shiftOp_t shiftDir;
    logic     isAddi;

    // Per-state operation picks
    always_comb begin
        isAddi = (state == Addi);
        case (state)
            Sub:     execAluOp = AluSub;
            And:     execAluOp = AluAnd;
            default: execAluOp = AluAdd; // add and addi
        endcase
        case (state)
            Sra:     shiftDir = ShRightArith;
            Srl:     shiftDir = ShRightLogic;
            default: shiftDir = ShLeft;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pcWrite     <= 1'b0;
            irWrite     <= 1'b0;
            regWrite    <= 1'b0;
            aWrite      <= 1'b0;
            bWrite      <= 1'b0;
            aluOutWrite <= 1'b0;
            aluOp       <= AluNone;
            srcASel     <= 1'b0;
            srcBSel     <= SrcBReg;
            regDestSel  <= DestRt;
            memToRegSel <= WbAlu;
            shiftAmtSel <= 1'b0;
            shiftSrcSel <= 1'b0;
            shiftOp     <= ShNone;
            resetOut    <= 1'b1;
        end else begin
            // Idle word
            pcWrite     <= 1'b0;
            irWrite     <= 1'b0;
            regWrite    <= 1'b0;
            aWrite      <= 1'b0;
            bWrite      <= 1'b0;
            aluOutWrite <= 1'b0;
            aluOp       <= AluNone;
            srcASel     <= 1'b0;
            srcBSel     <= SrcBReg;
            regDestSel  <= DestRt;
            memToRegSel <= WbAlu;
            shiftAmtSel <= 1'b0;
            shiftSrcSel <= 1'b0;
            shiftOp     <= ShNone;
            resetOut    <= 1'b0;

            case (state)
                Fetch: begin
                    if (step < 3'd4) begin
                        aluOp   <= AluAdd; // PC + 4
                        srcBSel <= SrcBFour;
                    end
                    if (step == 3'd3) begin
                        pcWrite <= 1'b1;
                        irWrite <= 1'b1;
                    end
                    if (step == 3'd4) begin
                        aWrite <= 1'b1; // Operand registers
                        bWrite <= 1'b1;
                    end
                end
                Add, Sub, And, Addi: begin
                    aluOp   <= execAluOp;
                    srcASel <= 1'b1;
                    if (isAddi) begin
                        srcBSel <= SrcBImm;
                    end
                    if (step == AluExecLast) begin
                        regWrite <= 1'b1;
                        if (!isAddi) begin
                            regDestSel <= DestRd;
                        end
                    end else begin
                        aluOutWrite <= 1'b1;
                    end
                end
                Sll, Sra, Srl: begin
                    memToRegSel <= WbShifter;
                    regDestSel  <= DestRd;
                    if (step == 3'd0) begin
                        shiftOp     <= ShLoad;
                        shiftAmtSel <= 1'b1; // shamt field
                        shiftSrcSel <= 1'b1;
                    end else if (step == ShiftExecLast) begin
                        shiftOp  <= ShLeft;
                        regWrite <= 1'b1;
                    end else begin
                        shiftOp <= shiftDir;
                    end
                end
                Slt: begin
                    aluOp       <= AluSlt;
                    srcASel     <= 1'b1;
                    regDestSel  <= DestRd;
                    memToRegSel <= WbLessThan;
                    regWrite    <= 1'b1;
                end
                Halt: begin
                    resetOut <= 1'b1;
                end
            endcase
        end
    end

    noWriteOverlap: assert property (@(posedge clock) disable iff (reset)
        !(regWrite && pcWrite));

    // One cycle later the halt word is on the outputs
    haltWordQuiet: assert property (@(posedge clock) disable iff (reset)
        state == Halt |=> resetOut && !(pcWrite || irWrite || regWrite || aWrite
            || bWrite || aluOutWrite) && aluOp == AluNone && shiftOp == ShNone);

endmodule

`default_nettype wire

// ==== hw/controlUnit.sv ====
`default_nettype none

module controlUnit (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  var  controlPkg::opcode_t   opcode,
    input  var  controlPkg::funct_t    funct,
    output logic                       pcWrite,
    output logic                       irWrite,
    output logic                       regWrite,
    output logic                       aWrite,
    output logic                       bWrite,
    output logic                       aluOutWrite,
    output controlPkg::aluOp_t         aluOp,
    output logic                       srcASel,
    output controlPkg::srcB_t          srcBSel,
    output controlPkg::regDest_t       regDestSel,
    output controlPkg::memToReg_t      memToRegSel,
    output logic                       shiftAmtSel,
    output logic                       shiftSrcSel,
    output controlPkg::shiftOp_t       shiftOp,
    output logic                       resetOut
);
    import controlPkg::*;

    state_t state;
    state_t execState;
    step_t  step;
    step_t  lastStep;
    logic   stepDone;
    logic   stepClear;
    logic   execValid;

    phaseSequencer phaseSequencer_i (
        .clock     (clock),
        .reset     (reset),
        .stepDone  (stepDone),
        .execState (execState),
        .execValid (execValid),
        .state     (state),
        .lastStep  (lastStep),
        .stepClear (stepClear)
    );

    stepCounter stepCounter_i (
        .clock     (clock),
        .reset     (reset),
        .lastStep  (lastStep),
        .stepClear (stepClear),
        .step      (step),
        .stepDone  (stepDone)
    );

    instructionDecoder instructionDecoder_i (
        .opcode    (opcode),
        .funct     (funct),
        .execState (execState),
        .execValid (execValid)
    );

    controlWordEncoder controlWordEncoder_i (
        .clock       (clock),
        .reset       (reset),
        .state       (state),
        .step        (step),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .aWrite      (aWrite),
        .bWrite      (bWrite),
        .aluOutWrite (aluOutWrite),
        .aluOp       (aluOp),
        .srcASel     (srcASel),
        .srcBSel     (srcBSel),
        .regDestSel  (regDestSel),
        .memToRegSel (memToRegSel),
        .shiftAmtSel (shiftAmtSel),
        .shiftSrcSel (shiftSrcSel),
        .shiftOp     (shiftOp),
        .resetOut    (resetOut)
    );

endmodule

`default_nettype wire

// ==== test/controlVectors.svh ====
    // Opcode and funct in, then execute length, regWrite count and the regWrite-cycle word
    typedef struct packed {
        opcode_t   opcode;
        funct_t    funct;
        int        execLength;
        int        regWrites;
        aluOp_t    aluOp;
        shiftOp_t  shiftOp;
        memToReg_t memToRegSel;
        regDest_t  regDestSel;
    } vector_t;

    localparam int VectorCount = 10;

    string   vectorNames[$];
    vector_t vectors[$];

    task automatic addVector(input string name, input opcode_t op, input funct_t fn,
            input int execLength, input int regWrites, input aluOp_t alu, input shiftOp_t shift,
            input memToReg_t wb, input regDest_t dest);
        vector_t entry;
        entry.opcode      = op;
        entry.funct       = fn;
        entry.execLength  = execLength;
        entry.regWrites   = regWrites;
        entry.aluOp       = alu;
        entry.shiftOp     = shift;
        entry.memToRegSel = wb;
        entry.regDestSel  = dest;
        vectorNames.push_back(name);
        vectors.push_back(entry);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Instruction table
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic loadVectors();
        // name          opcode            funct            len wr  aluOp    shiftOp
        addVector("add",        RType,            AddFn,           2, 1, AluAdd,  ShNone,
            WbAlu, DestRd); // Entry 0 is reused after halt
        addVector("sub",        RType,            SubFn,           2, 1, AluSub,  ShNone,
            WbAlu, DestRd);
        addVector("and",        RType,            AndFn,           2, 1, AluAnd,  ShNone,
            WbAlu, DestRd);
        addVector("slt",        RType,            SltFn,           1, 1, AluSlt,  ShNone,
            WbLessThan, DestRd);
        addVector("sll",        RType,            SllFn,           3, 1, AluNone, ShLeft,
            WbShifter, DestRd);
        addVector("sra",        RType,            SraFn,           3, 1, AluNone, ShLeft,
            WbShifter, DestRd);
        addVector("srl",        RType,            SrlFn,           3, 1, AluNone, ShLeft,
            WbShifter, DestRd);
        addVector("addi",       AddiOp,           SubFn,           2, 1, AluAdd,  ShNone,
            WbAlu, DestRt); // funct is don't care
        addVector("bad funct",  RType,            funct_t'(6'h3f), 0, 0, AluNone, ShNone,
            WbAlu, DestRt);
        addVector("bad opcode", opcode_t'(6'h04), AddFn,           0, 0, AluNone, ShNone,
            WbAlu, DestRt);
    endtask

// ==== test/controlUnitTb.sv ====
`default_nettype none

module controlUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    import controlPkg::*;

    localparam int ResetCycles = 16;
    localparam int HaltCycles  = 20;
    localparam int WaitLimit   = 20; // Longest gap between irWrite pulses is 9

    logic      clock;
    logic      reset;
    opcode_t   opcode;
    funct_t    funct;
    logic      pcWrite, irWrite, regWrite, aWrite, bWrite, aluOutWrite;
    logic      srcASel, shiftAmtSel, shiftSrcSel, resetOut;
    aluOp_t    aluOp;
    srcB_t     srcBSel;
    regDest_t  regDestSel;
    memToReg_t memToRegSel;
    shiftOp_t  shiftOp;

    int errorCount;
    int testCount;
    int failedTests;
    int order[$];

    `include "controlVectors.svh"

    // Ten cycles per applied instruction plus both resets
    localparam int WatchdogCycles = (2 * VectorCount + 4) * 10 + 2 * ResetCycles;

    controlUnit controlUnit_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #(WatchdogCycles * 10);
        $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic reportMismatch(input string testName, input string what, input string expected,
            input string actual);
        $display("** Error %s: %s expected %s, actual %s", testName, what, expected, actual);
        errorCount++;
    endtask

    task automatic checkBit(input string testName, input string what, input logic expected,
            input logic actual);
        if (actual !== expected) begin
            reportMismatch(testName, what, $sformatf("%b", expected), $sformatf("%b", actual));
        end
    endtask

    task automatic checkCount(input string testName, input string what, input int expected,
            input int actual);
        if (actual != expected) begin
            reportMismatch(testName, what, $sformatf("%0d", expected), $sformatf("%0d", actual));
        end
    endtask

    task automatic checkAluOp(input string testName, input aluOp_t expected, input aluOp_t actual);
        if (actual !== expected) begin
            reportMismatch(testName, "aluOp", expected.name(), actual.name());
        end
    endtask

    task automatic checkShiftOp(input string testName, input shiftOp_t expected,
            input shiftOp_t actual);
        if (actual !== expected) begin
            reportMismatch(testName, "shiftOp", expected.name(), actual.name());
        end
    endtask

    task automatic checkMemToReg(input string testName, input memToReg_t expected,
            input memToReg_t actual);
        if (actual !== expected) begin
            reportMismatch(testName, "memToRegSel", expected.name(), actual.name());
        end
    endtask

    task automatic checkRegDest(input string testName, input regDest_t expected,
            input regDest_t actual);
        if (actual !== expected) begin
            reportMismatch(testName, "regDestSel", expected.name(), actual.name());
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Sequencing helpers
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic nextCycle();
        @(posedge clock);
        #1; // Outputs settled, inputs may change
    endtask

    task automatic finishTest(input string testName, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("PASS %s", testName);
        end else begin
            failedTests++;
            $display("FAIL %s", testName);
        end
    endtask

    // Reset word and halt word are the same
    task automatic checkQuietWord(input string testName);
        checkBit(testName, "resetOut", 1'b1, resetOut);
        checkBit(testName, "any strobe or select", 1'b0, |{pcWrite, irWrite, regWrite, aWrite,
            bWrite, aluOutWrite, srcASel, shiftAmtSel, shiftSrcSel});
        checkBit(testName, "srcBSel is SrcBReg", 1'b1, srcBSel == SrcBReg);
        checkAluOp(testName, AluNone, aluOp);
        checkShiftOp(testName, ShNone, shiftOp);
        checkMemToReg(testName, WbAlu, memToRegSel);
        checkRegDest(testName, DestRt, regDestSel);
    endtask

    task automatic holdReset(input string testName);
        int errorsBefore;
        errorsBefore = errorCount;
        reset = 1'b1;
        repeat (ResetCycles) begin
            nextCycle();
            checkQuietWord(testName);
        end
        reset = 1'b0;
        nextCycle(); // First fetch word
        checkBit(testName, "resetOut after release", 1'b0, resetOut);
        checkAluOp(testName, AluAdd, aluOp);
        checkBit(testName, "srcBSel is SrcBFour", 1'b1, srcBSel == SrcBFour);
        finishTest(testName, errorsBefore);
    endtask

    task automatic waitIrWrite(input string testName);
        int waited;
        waited = 0;
        while (irWrite !== 1'b1 && waited < WaitLimit) begin
            nextCycle();
            waited++;
        end
        if (irWrite !== 1'b1) begin
            $display("%s: no irWrite pulse within %0d cycles", testName, WaitLimit);
            errorCount++;
        end
    endtask

    // Starts and ends on an irWrite cycle
    task automatic runInstruction(input int index, input opcode_t nextOpcode,
            input funct_t nextFunct);
        string   testName;
        vector_t vec;
        int      errorsBefore;
        int      cycles;
        int      writes;
        int      fetchRun;
        testName     = vectorNames[index];
        vec          = vectors[index];
        errorsBefore = errorCount;
        writes       = 0;
        fetchRun     = 0;
        checkBit(testName, "pcWrite with irWrite", 1'b1, pcWrite);
        nextCycle();
        checkBit(testName, "aWrite", 1'b1, aWrite);
        checkBit(testName, "bWrite", 1'b1, bWrite);
        checkBit(testName, "irWrite width", 1'b0, irWrite);
        cycles = 1;
        while (cycles < WaitLimit) begin
            nextCycle();
            cycles++;
            if (cycles == 2) begin
                opcode = nextOpcode; // Decode edge is behind us
                funct  = nextFunct;
            end
            fetchRun = (aluOp == AluAdd && srcBSel == SrcBFour) ? fetchRun + 1 : 0;
            if (irWrite === 1'b1) begin
                break;
            end
            checkBit(testName, "pcWrite", 1'b0, pcWrite);
            checkBit(testName, "aWrite or bWrite", 1'b0, aWrite | bWrite);
            checkBit(testName, "resetOut", 1'b0, resetOut);
            if (regWrite === 1'b1) begin
                writes++;
                checkAluOp(testName, vec.aluOp, aluOp);
                checkShiftOp(testName, vec.shiftOp, shiftOp);
                checkMemToReg(testName, vec.memToRegSel, memToRegSel);
                checkRegDest(testName, vec.regDestSel, regDestSel);
            end
        end
        if (irWrite !== 1'b1) begin
            $display("%s: next irWrite pulse missing after %0d cycles", testName, cycles);
            errorCount++;
        end
        checkCount(testName, "cycles between irWrite pulses", 6 + vec.execLength, cycles);
        checkCount(testName, "regWrite pulses", vec.regWrites, writes);
        checkCount(testName, "PC increment cycles", 4, fetchRun);
        finishTest(testName, errorsBefore);
    endtask

    task automatic runHalt();
        int errorsBefore;
        int waited;
        errorsBefore = errorCount;
        waited       = 0;
        checkBit("halt", "pcWrite with irWrite", 1'b1, pcWrite);
        while (resetOut !== 1'b1 && waited < WaitLimit) begin
            nextCycle();
            waited++;
        end
        if (resetOut !== 1'b1) begin
            $display("halt: resetOut did not rise within %0d cycles", WaitLimit);
            errorCount++;
        end
        repeat (HaltCycles) begin
            nextCycle();
            checkQuietWord("halt");
        end
        finishTest("halt", errorsBefore);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        int shuffled[VectorCount];
        int pick;
        int temp;
        void'($urandom(32'h5d08_d42d));
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        reset       = 1'b1;
        opcode      = RType;
        funct       = AddFn;
        loadVectors();
        if (vectors.size() != VectorCount) begin
            $display("Instruction table holds %0d entries instead of %0d", vectors.size(),
                VectorCount);
            errorCount++;
        end

        // Table order, then a shuffled pass
        for (int i = 0; i < VectorCount; i++) begin
            order.push_back(i);
            shuffled[i] = i;
        end
        for (int i = VectorCount - 1; i > 0; i--) begin
            pick           = $urandom_range(i, 0);
            temp           = shuffled[i];
            shuffled[i]    = shuffled[pick];
            shuffled[pick] = temp;
        end
        for (int i = 0; i < VectorCount; i++) begin
            order.push_back(shuffled[i]);
        end

        opcode = vectors[order[0]].opcode;
        funct  = vectors[order[0]].funct;
        holdReset("reset");
        waitIrWrite("first fetch");
        for (int k = 0; k < order.size(); k++) begin
            if (k + 1 < order.size()) begin
                runInstruction(order[k], vectors[order[k + 1]].opcode, vectors[order[k + 1]].funct);
            end else begin
                runInstruction(order[k], HaltOp, AddFn);
            end
        end
        runHalt();

        // Fetch must work again after halt
        opcode = vectors[0].opcode;
        funct  = vectors[0].funct;
        holdReset("reset after halt");
        waitIrWrite("fetch after halt");
        runInstruction(0, vectors[0].opcode, vectors[0].funct);

        $display("Tests: %0d run, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+test
common/control_pkg.sv
hw/sequencer/stepCounter.sv
hw/sequencer/phaseSequencer.sv
hw/instructionDecoder.sv
hw/controlWordEncoder.sv
hw/controlUnit.sv
test/controlUnitTb.sv
